// ==== sparse_pkg.sv ====
`default_nettype none

package sparse_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	// Channels per sparsemap word
	localparam int PREFIX_SUM_SIZE = 8;
	// Depth of the compressed IFM buffer
	localparam int MEM_SIZE        = 64;
	localparam int CHUNK_WORDS     = MEM_SIZE / PREFIX_SUM_SIZE;
	localparam int DATA_W          = 8;

	localparam int CH_IDX_W   = $clog2(PREFIX_SUM_SIZE);
	localparam int WORD_IDX_W = $clog2(CHUNK_WORDS);
	// One extra bit so a full chunk count fits
	localparam int ADDR_W     = $clog2(MEM_SIZE) + 1;
	// Channel number within the chunk, word index over bit index
	localparam int CHAN_W     = WORD_IDX_W + CH_IDX_W;

	////////////////////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////////////////////

	typedef logic [PREFIX_SUM_SIZE-1:0] smap_t;

	typedef struct packed {
		smap_t                 ifm_map;
		smap_t                 wgt_map;
		logic [WORD_IDX_W-1:0] word_idx;
		logic                  last_word;
		logic                  valid;
	} fetch_word_t;

	typedef struct packed {
		smap_t                 ifm_map;
		logic [CH_IDX_W-1:0]   match_addr;
		logic [WORD_IDX_W-1:0] word_idx;
		logic                  hit;
		logic                  word_end;
		logic                  last_word;
		logic                  valid;
	} match_t;

	typedef struct packed {
		logic [ADDR_W-1:0] rd_addr;
		logic [CHAN_W-1:0] channel;
		logic              last;
		logic              valid;
	} gather_addr_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [CHAN_W-1:0] channel;
		logic              last;
		logic              valid;
	} gather_out_t;

endpackage

`default_nettype wire

// ==== prefix_sum.sv ====
`timescale 1ns/1ps
`default_nettype none

// Exclusive count of ones below each bit of one sparsemap word
module prefix_sum import sparse_pkg::*; (
	input  smap_t             map_i,
	output logic [ADDR_W-1:0] count_o [PREFIX_SUM_SIZE],
	output logic [ADDR_W-1:0] total_o
);

	logic [ADDR_W-1:0] acc_w [PREFIX_SUM_SIZE+1];

	// Ripple chain, short enough for one word
	always_comb begin
		acc_w[0] = '0;
		for (int k = 0; k < PREFIX_SUM_SIZE; k++) begin
			acc_w[k+1] = acc_w[k] + ADDR_W'(map_i[k]);
		end
	end

	always_comb begin
		for (int k = 0; k < PREFIX_SUM_SIZE; k++) begin
			count_o[k] = acc_w[k];
		end
	end

	// Entry past the top bit is the word total
	assign total_o = acc_w[PREFIX_SUM_SIZE];

endmodule

`default_nettype wire

// ==== sparsemap_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module sparsemap_fetch import sparse_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  smap_we_i,
	input  logic [WORD_IDX_W-1:0] smap_waddr_i,
	input  smap_t                 ifm_map_i,
	input  smap_t                 wgt_map_i,
	input  logic [WORD_IDX_W-1:0] chunk_last_i,
	input  logic                  chunk_start_i,
	input  logic                  next_word_i,
	output fetch_word_t           word_o
);

	smap_t                 ifm_mem_r [CHUNK_WORDS];
	smap_t                 wgt_mem_r [CHUNK_WORDS];
	logic [WORD_IDX_W-1:0] word_cnt_r;
	logic                  busy_r;

	logic                  advance_w;
	logic                  present_w;
	logic [WORD_IDX_W-1:0] sel_idx_w;

	// Sparsemap chunk storage
	always_ff @(posedge clk_i) begin
		if (smap_we_i) begin
			ifm_mem_r[smap_waddr_i] <= ifm_map_i;
			wgt_mem_r[smap_waddr_i] <= wgt_map_i;
		end
	end

	// A request on the cycle a word is shown belongs to the previous walk
	assign advance_w = busy_r && next_word_i && !word_o.valid && (word_cnt_r != chunk_last_i);
	assign present_w = chunk_start_i || advance_w;
	assign sel_idx_w = chunk_start_i ? '0 : word_cnt_r + 1'b1;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_r       <= 1'b0;
			word_cnt_r   <= '0;
			word_o.valid <= 1'b0;
		end else begin
			word_o.valid <= present_w;
			if (present_w) begin
				word_cnt_r       <= sel_idx_w;
				busy_r           <= 1'b1;
				word_o.ifm_map   <= ifm_mem_r[sel_idx_w];
				word_o.wgt_map   <= wgt_mem_r[sel_idx_w];
				word_o.word_idx  <= sel_idx_w;
				word_o.last_word <= (sel_idx_w == chunk_last_i);
			end else if (busy_r && next_word_i && !word_o.valid) begin
				// Last word consumed
				busy_r <= 1'b0;
			end
		end
	end

	// Maps must not change under a running walk
	assert property (@(posedge clk_i) disable iff (rst_i) busy_r |-> !smap_we_i);

endmodule

`default_nettype wire

// ==== match_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module match_encoder import sparse_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  fetch_word_t word_i,
	output logic        next_word_o,
	output match_t      match_o
);

	smap_t               ifm_r;
	smap_t               wgt_r;
	smap_t               pend_r;
	logic                busy_r;
	logic [WORD_IDX_W-1:0] word_idx_r;
	logic                last_word_r;

	logic                load_w;
	logic                active_w;
	smap_t               src_w;
	smap_t               remain_w;
	logic [CH_IDX_W-1:0] low_idx_w;

	////////////////////////////////////////////////////////////////////////////
	// Lowest common channel of the current word
	////////////////////////////////////////////////////////////////////////////

	assign load_w   = word_i.valid;
	assign active_w = load_w || busy_r;
	assign src_w    = load_w ? (word_i.ifm_map & word_i.wgt_map) : pend_r;
	// Drop the lowest set bit
	assign remain_w = src_w & (src_w - smap_t'(1));

	always_comb begin
		low_idx_w = '0;
		for (int i = PREFIX_SUM_SIZE - 1; i >= 0; i--) begin
			if (src_w[i]) begin
				low_idx_w = CH_IDX_W'(i);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Word state and registered match
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (load_w) begin
			ifm_r       <= word_i.ifm_map;
			wgt_r       <= word_i.wgt_map;
			word_idx_r  <= word_i.word_idx;
			last_word_r <= word_i.last_word;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_r        <= 1'b0;
			next_word_o   <= 1'b0;
			match_o.valid <= 1'b0;
		end else begin
			match_o.valid <= active_w;
			// Request the next word together with word_end
			next_word_o   <= active_w && (remain_w == '0);
			if (active_w) begin
				busy_r             <= (remain_w != '0);
				pend_r             <= remain_w;
				match_o.ifm_map    <= load_w ? word_i.ifm_map : ifm_r;
				match_o.word_idx   <= load_w ? word_i.word_idx : word_idx_r;
				match_o.last_word  <= load_w ? word_i.last_word : last_word_r;
				match_o.match_addr <= low_idx_w;
				match_o.hit        <= |src_w;
				match_o.word_end   <= (remain_w == '0);
			end
		end
	end

	// A hit must point at a channel set in both maps
	assert property (@(posedge clk_i) disable iff (rst_i)
		match_o.valid && match_o.hit |->
			match_o.ifm_map[match_o.match_addr] && wgt_r[match_o.match_addr]);

endmodule

`default_nettype wire

// ==== ifm_input_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifm_input_sel import sparse_pkg::*; (
	input  logic         clk_i,
	input  logic         rst_i,
	input  logic         chunk_start_i,
	input  match_t       match_i,
	output gather_addr_t addr_o
);

	logic [ADDR_W-1:0] prefix_w [PREFIX_SUM_SIZE];
	logic [ADDR_W-1:0] total_w;
	logic [ADDR_W-1:0] base_addr_r;
	logic              start_d_r;
	logic              take_w;

	prefix_sum u_prefix_sum (
		.map_i   (match_i.ifm_map),
		.count_o (prefix_w),
		.total_o (total_w)
	);

	// The match seen right after a start still comes from the old walk
	assign take_w = match_i.valid && !start_d_r;

	// Base of the current word in the compressed buffer
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			base_addr_r <= '0;
			start_d_r   <= 1'b0;
		end else begin
			start_d_r <= chunk_start_i;
			if (chunk_start_i) begin
				base_addr_r <= '0;
			end else if (take_w && match_i.word_end) begin
				base_addr_r <= base_addr_r + total_w;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			addr_o.valid <= 1'b0;
			addr_o.last  <= 1'b0;
		end else begin
			addr_o.valid   <= take_w && match_i.hit;
			// Marker goes out even when the last word has no hit
			addr_o.last    <= take_w && match_i.word_end && match_i.last_word;
			addr_o.rd_addr <= base_addr_r + prefix_w[match_i.match_addr];
			addr_o.channel <= {match_i.word_idx, match_i.match_addr};
		end
	end

	assert property (@(posedge clk_i) disable iff (rst_i)
		addr_o.valid |-> (addr_o.rd_addr < ADDR_W'(MEM_SIZE)));

endmodule

`default_nettype wire

// ==== ifm_data_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifm_data_buffer import sparse_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              data_we_i,
	input  logic [ADDR_W-2:0] data_waddr_i,
	input  logic [DATA_W-1:0] data_i,
	input  gather_addr_t      addr_i,
	output gather_out_t       gather_o
);

	logic [DATA_W-1:0] mem_r [MEM_SIZE];

	// Compressed nonzero IFM values
	always_ff @(posedge clk_i) begin
		if (data_we_i) begin
			mem_r[data_waddr_i] <= data_i;
		end
	end

	// Registered read, tags travel alongside
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			gather_o.valid <= 1'b0;
			gather_o.last  <= 1'b0;
		end else begin
			gather_o.valid   <= addr_i.valid;
			gather_o.last    <= addr_i.last;
			gather_o.data    <= mem_r[addr_i.rd_addr[ADDR_W-2:0]];
			gather_o.channel <= addr_i.channel;
		end
	end

endmodule

`default_nettype wire

// ==== sparse_gather_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sparse_gather_top import sparse_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  smap_we_i,
	input  logic [WORD_IDX_W-1:0] smap_waddr_i,
	input  smap_t                 ifm_map_i,
	input  smap_t                 wgt_map_i,
	input  logic                  data_we_i,
	input  logic [ADDR_W-2:0]     data_waddr_i,
	input  logic [DATA_W-1:0]     data_i,
	input  logic [WORD_IDX_W-1:0] chunk_last_i,
	input  logic                  chunk_start_i,
	output gather_out_t           gather_o,
	output logic                  chunk_done_o
);

	fetch_word_t  fetch_word_w;
	logic         next_word_w;
	match_t       match_w;
	gather_addr_t gather_addr_w;

	sparsemap_fetch u_sparsemap_fetch (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.smap_we_i     (smap_we_i),
		.smap_waddr_i  (smap_waddr_i),
		.ifm_map_i     (ifm_map_i),
		.wgt_map_i     (wgt_map_i),
		.chunk_last_i  (chunk_last_i),
		.chunk_start_i (chunk_start_i),
		.next_word_i   (next_word_w),
		.word_o        (fetch_word_w)
	);

	match_encoder u_match_encoder (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.word_i      (fetch_word_w),
		.next_word_o (next_word_w),
		.match_o     (match_w)
	);

	ifm_input_sel u_ifm_input_sel (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.chunk_start_i (chunk_start_i),
		.match_i       (match_w),
		.addr_o        (gather_addr_w)
	);

	ifm_data_buffer u_ifm_data_buffer (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.data_we_i    (data_we_i),
		.data_waddr_i (data_waddr_i),
		.data_i       (data_i),
		.addr_i       (gather_addr_w),
		.gather_o     (gather_o)
	);

	// Last marker reaches the output even with valid low
	assign chunk_done_o = gather_o.last;

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running 20 ns clock, reset held over the first four rising edges
module tb_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// Released on a falling edge, away from the sampling edge
	initial begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tb_sparse_gather.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sparse_gather import sparse_pkg::*; ();

	localparam int NUM_CHUNKS = 8;

	logic                  clk_i;
	logic                  rst_i;
	logic                  smap_we_i;
	logic [WORD_IDX_W-1:0] smap_waddr_i;
	smap_t                 ifm_map_i;
	smap_t                 wgt_map_i;
	logic                  data_we_i;
	logic [ADDR_W-2:0]     data_waddr_i;
	logic [DATA_W-1:0]     data_i;
	logic [WORD_IDX_W-1:0] chunk_last_i;
	logic                  chunk_start_i;
	gather_out_t           gather_o;
	logic                  chunk_done_o;

	// Chunk image kept by the testbench
	smap_t             ifm_m [CHUNK_WORDS];
	smap_t             wgt_m [CHUNK_WORDS];
	logic [DATA_W-1:0] data_m [MEM_SIZE];
	gather_out_t       exp_q [$];
	int                done_cnt = 0;
	logic [31:0]       lcg_state = 32'd68;

	tb_clk_gen u_clk_gen (
		.clk_o (clk_i),
		.rst_o (rst_i)
	);

	sparse_gather_top u_sparse_gather_top (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.smap_we_i     (smap_we_i),
		.smap_waddr_i  (smap_waddr_i),
		.ifm_map_i     (ifm_map_i),
		.wgt_map_i     (wgt_map_i),
		.data_we_i     (data_we_i),
		.data_waddr_i  (data_waddr_i),
		.data_i        (data_i),
		.chunk_last_i  (chunk_last_i),
		.chunk_start_i (chunk_start_i),
		.gather_o      (gather_o),
		.chunk_done_o  (chunk_done_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// Kind 0 dense, kind 1 random, kind 2 disjoint words and an empty last word
	task automatic fill_maps(input int kind);
		for (int w = 0; w < CHUNK_WORDS; w++) begin
			case (kind)
				0: begin
					ifm_m[w] = '1;
					wgt_m[w] = '1;
				end
				1: begin
					ifm_m[w] = rand_byte();
					wgt_m[w] = rand_byte();
				end
				default: begin
					ifm_m[w] = rand_byte();
					wgt_m[w] = (w % 2 == 0) ? ~ifm_m[w] : rand_byte();
				end
			endcase
		end
		if (kind == 2) begin
			ifm_m[3] = '0;
			wgt_m[3] = '0;
			ifm_m[CHUNK_WORDS-1] = '0;
			wgt_m[CHUNK_WORDS-1] = '0;
		end
		for (int i = 0; i < MEM_SIZE; i++) begin
			data_m[i] = rand_byte();
		end
	endtask

	// Maps go in during the first eight data writes
	task automatic load_chunk();
		for (int i = 0; i < MEM_SIZE; i++) begin
			@(negedge clk_i);
			data_we_i    = 1'b1;
			data_waddr_i = (ADDR_W-1)'(i);
			data_i       = data_m[i];
			smap_we_i    = (i < CHUNK_WORDS);
			if (i < CHUNK_WORDS) begin
				smap_waddr_i = WORD_IDX_W'(i);
				ifm_map_i    = ifm_m[i];
				wgt_map_i    = wgt_m[i];
			end
		end
		@(negedge clk_i);
		data_we_i = 1'b0;
		smap_we_i = 1'b0;
	endtask

	// Reference walk over channels low to high with the address as the IFM ones before it
	function automatic void build_expected(input logic [WORD_IDX_W-1:0] last_idx);
		int          ones;
		int          top_bit;
		gather_out_t item;
		ones    = 0;
		top_bit = -1;
		for (int w = 0; w <= int'(last_idx); w++) begin
			top_bit = -1;
			for (int b = 0; b < PREFIX_SUM_SIZE; b++) begin
				if (ifm_m[w][b] && wgt_m[w][b]) begin
					top_bit = b;
				end
			end
			for (int b = 0; b < PREFIX_SUM_SIZE; b++) begin
				if (ifm_m[w][b] && wgt_m[w][b]) begin
					item.valid   = 1'b1;
					item.data    = data_m[ones[5:0]];
					item.channel = CHAN_W'(w * PREFIX_SUM_SIZE + b);
					item.last    = (w == int'(last_idx)) && (b == top_bit);
					exp_q.push_back(item);
				end
				if (ifm_m[w][b]) begin
					ones++;
				end
			end
		end
		// Last word without matches still ends the chunk with no data
		if (top_bit < 0) begin
			item = '0;
			item.last = 1'b1;
			exp_q.push_back(item);
		end
	endfunction

	task automatic run_chunk(input logic [WORD_IDX_W-1:0] last_idx);
		int prev_done;
		prev_done = done_cnt;
		build_expected(last_idx);
		@(negedge clk_i);
		chunk_last_i  = last_idx;
		chunk_start_i = 1'b1;
		@(negedge clk_i);
		chunk_start_i = 1'b0;
		while (done_cnt == prev_done) begin
			@(negedge clk_i);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("FAIL: see errors above");
		$fatal(1, "%s", why);
	endtask

	task automatic check_item(input gather_out_t got, input gather_out_t exp);
		if (got.valid !== exp.valid) begin
			$display("Error at %0t: gather valid got %b expected %b", $time, got.valid, exp.valid);
			fail_run("gather valid mismatch");
		end else if (exp.valid && got.channel !== exp.channel) begin
			$display("Error at %0t: channel got %0d expected %0d", $time, got.channel,
				exp.channel);
			fail_run("gather channel mismatch");
		end else if (exp.valid && got.data !== exp.data) begin
			$display("Error at %0t: data for channel %0d got %h expected %h", $time,
				exp.channel, got.data, exp.data);
			fail_run("gather data mismatch");
		end
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: chunk_done_o got %b expected %b", $time, got, exp);
			fail_run("chunk_done_o mismatch");
		end
	endtask

	// Registered outputs are settled at the falling edge
	initial begin : compare_proc
		gather_out_t exp;
		wait (rst_i === 1'b0);
		forever begin
			@(negedge clk_i);
			if (gather_o.valid || chunk_done_o) begin
				if (exp_q.size() == 0) begin
					$display("The DUT produced an output while nothing was expected");
					fail_run("unexpected output");
				end else begin
					exp = exp_q.pop_front();
					check_item(gather_o, exp);
					check_done(chunk_done_o, exp.last);
					if (chunk_done_o) begin
						done_cnt++;
					end
				end
			end
		end
	end

	initial begin : watchdog
		repeat (200 * NUM_CHUNKS) @(posedge clk_i);
		$display("The watchdog expired before all chunks had finished");
		fail_run("timeout");
	end

	initial begin : stimulus
		smap_we_i     = 1'b0;
		smap_waddr_i  = '0;
		ifm_map_i     = '0;
		wgt_map_i     = '0;
		data_we_i     = 1'b0;
		data_waddr_i  = '0;
		data_i        = '0;
		chunk_last_i  = '1;
		chunk_start_i = 1'b0;
		wait (rst_i === 1'b0);
		// Idle window with no start
		repeat (10) @(negedge clk_i);
		fill_maps(0);
		load_chunk();
		run_chunk(3'd7);
		for (int n = 0; n < 4; n++) begin
			fill_maps(1);
			load_chunk();
			run_chunk(3'd7);
		end
		fill_maps(2);
		load_chunk();
		run_chunk(3'd7);
		// Short chunk twice in a row so the base has to restart
		fill_maps(1);
		load_chunk();
		run_chunk(3'd4);
		run_chunk(3'd4);
		repeat (10) @(negedge clk_i);
		if (exp_q.size() == 0 && done_cnt == NUM_CHUNKS) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("Run ended with %0d items left and %0d done pulses", exp_q.size(),
				done_cnt);
			fail_run("incomplete run");
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
sparse_pkg.sv
prefix_sum.sv
sparsemap_fetch.sv
match_encoder.sv
ifm_input_sel.sv
ifm_data_buffer.sv
sparse_gather_top.sv
tb_clk_gen.sv
tb_sparse_gather.sv

// ==== Makefile ====
TOP := tb_sparse_gather

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f $(wildcard *.sv)
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
